// File: filelist.f
+incdir+tb
hdl/mem_pkg.sv
hdl/mem_pipe_reg.sv
hdl/store_forward.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/wb_select.sv
hdl/mem_stage.sv
tb/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/mem_pipe_reg.sv
      - hdl/store_forward.sv
      - hdl/store_align.sv
      - hdl/load_extract.sv
      - hdl/wb_select.sv
      - hdl/mem_stage.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_mem_stage.sv

// File: tb/mem_ref.svh
// memory stage reference model
// expected load values, store word updates and rf values, plus the
// compare tasks used by the checker
`ifndef MEM_REF_SVH
`define MEM_REF_SVH

// bytes moved by one access
function automatic int unsigned access_bytes(mem_op_t op);
    case (op)
        op_lb, op_lbu, op_sb: return 1;
        op_lh, op_lhu, op_sh: return 2;
        op_lw, op_lwu, op_sw: return 4;
        default:              return 8;
    endcase
endfunction

// old word with the store bytes laid over it
function automatic xlen_t store_word(xlen_t old, mem_op_t op, xlen_t addr, xlen_t data);
    xlen_t       w;
    int unsigned off;
    w   = old;
    off = addr[2:0];
    for (int i = 0; i < access_bytes(op); i++) begin
        w[(off + i) * 8 +: 8] = data[i * 8 +: 8];
    end
    return w;
endfunction

// one strobe bit per stored byte
function automatic strb_t store_strobe(mem_op_t op, xlen_t addr);
    strb_t       s;
    int unsigned off;
    s   = '0;
    off = addr[2:0];
    for (int i = 0; i < access_bytes(op); i++) begin
        s[off + i] = 1'b1;
    end
    return s;
endfunction

// addressed bytes, then sign or zero fill
function automatic xlen_t load_value(xlen_t word, mem_op_t op, xlen_t addr);
    xlen_t       v;
    int unsigned off;
    int unsigned n;
    logic        sign;
    v   = '0;
    off = addr[2:0];
    n   = access_bytes(op);
    for (int i = 0; i < n; i++) begin
        v[i * 8 +: 8] = word[(off + i) * 8 +: 8];
    end
    sign = v[n * 8 - 1];
    if (op inside {op_lb, op_lh, op_lw}) begin
        for (int b = n * 8; b < xlen; b++) begin
            v[b] = sign;                           // sign extension
        end
    end
    return v;
endfunction

task automatic check_rf_write(rf_write_t got, rf_write_t exp);
    if (got.wen !== exp.wen || (exp.wen && (got.rd !== exp.rd || got.value !== exp.value))) begin
        $display("CHECK FAILED rf_wr: wen=%h rd=%h value=%h, expected wen=%h rd=%h value=%h",
                 got.wen, got.rd, got.value, exp.wen, exp.rd, exp.value);
        stop_run();
    end
endtask

task automatic check_mem_wb(mem_wb_t got, mem_wb_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED wb: valid=%h pc=%h inst=%h, expected valid=%h pc=%h inst=%h",
                 got.valid, got.pc, got.inst, exp.valid, exp.pc, exp.inst);
        stop_run();
    end
endtask

// data bytes only count where the strobe is set
task automatic check_dmem_req(dmem_req_t got, dmem_req_t exp);
    xlen_t lane_mask;
    for (int b = 0; b < 8; b++) begin
        lane_mask[b * 8 +: 8] = {8{exp.strb[b]}};
    end
    if (got.valid !== exp.valid || got.we !== exp.we
        || (exp.valid && got.addr !== exp.addr)
        || (exp.we && (got.strb !== exp.strb
                       || (got.wdata & lane_mask) !== (exp.wdata & lane_mask)))) begin
        $display("CHECK FAILED dmem_req: got %h, expected %h", got, exp);
        stop_run();
    end
endtask

task automatic check_word(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        stop_run();
    end
endtask

`endif

// File: tb/tb_mem_stage.sv
// memory stage testbench
// runs alu, link, csr, load and store sequences through the stage with
// a random-latency data memory and random write-back back-pressure
module tb_mem_stage import mem_pkg::*; ();

    localparam xlen_t       mem_base  = 64'h1000;
    localparam int          mem_words = 64;
    localparam int unsigned seed      = 32'hab0f_2a96;

    typedef struct {
        ex_mem_t     ex;
        mem_wb_t     wb;
        rf_write_t   rf;
        dmem_req_t   req;                          // data port request
        logic        is_store;
        int unsigned widx;                         // word touched by a store
        xlen_t       word;                         // word after the store
    } inst_item_t;

    logic      clk;
    logic      rst;
    ex_mem_t   ex;
    logic      ex_ready;
    mem_wb_t   wb;
    logic      wb_ready;
    rf_write_t rf_wr;
    wb_fwd_t   fwd;
    dmem_req_t dmem_req;
    logic      dmem_ready;
    xlen_t     dmem_rdata;

    xlen_t       mem_arr [mem_words];              // memory seen by the DUT
    xlen_t       shadow [mem_words];               // program-order model
    inst_item_t  prog [$];
    xlen_t       next_pc;
    logic        prev_writer;                      // last inst writes rd
    reg_idx_t    prev_rd;
    xlen_t       prev_val;
    int unsigned retired;
    int unsigned cycles;
    int unsigned limit;
    int unsigned lat_cnt;
    logic        word_check_due;
    int unsigned check_widx;
    xlen_t       check_word_exp;
    mem_op_t     ld_ops [7] = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    mem_op_t     st_ops [4] = '{op_sb, op_sh, op_sw, op_sd};

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    `include "mem_ref.svh"

    mem_stage i_mem_stage (
        .clk        (clk),
        .rst        (rst),
        .ex         (ex),
        .ex_ready   (ex_ready),
        .wb         (wb),
        .wb_ready   (wb_ready),
        .rf_wr      (rf_wr),
        .fwd        (fwd),
        .dmem_req   (dmem_req),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata)
    );

    assign dmem_rdata = mem_arr[dmem_req.addr[8:3]];   // same-cycle read

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ************************************************************
    // program builder
    // ************************************************************
    function automatic xlen_t fill_word(xlen_t addr);
        return (addr * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic xlen_t word_addr(int unsigned w, int unsigned off);
        return mem_base + xlen_t'(w * 8 + off);
    endfunction

    function automatic logic [2:0] size_funct3(mem_op_t op);
        case (op)
            op_lb, op_sb: return 3'd0;
            op_lh, op_sh: return 3'd1;
            op_lw, op_sw: return 3'd2;
            op_lbu:       return 3'd4;
            op_lhu:       return 3'd5;
            op_lwu:       return 3'd6;
            default:      return 3'd3;                 // ld, sd
        endcase
    endfunction

    task automatic add_inst(mem_op_t op, reg_idx_t rd, reg_idx_t rs2, xlen_t alu, xlen_t src2);
        inst_item_t  it;
        logic [31:0] raw;
        xlen_t       data;
        xlen_t       value;
        case (op)
            op_alu:  raw = {7'b0, rs2, 5'd1, 3'b000, rd, opc_op};            // add
            op_link: raw = {20'h00010, rd, 7'b1101111};                      // jal
            op_csr:  raw = {12'h340, 5'd2, 3'b001, rd, opc_system};          // csrrw
            op_sb, op_sh, op_sw, op_sd:
                     raw = {7'h00, rs2, 5'd3, size_funct3(op), rd, opc_store};
            default: raw = {12'h010, 5'd3, size_funct3(op), rd, opc_load};
        endcase
        it.ex.valid   = 1'b1;
        it.ex.pc      = next_pc;
        it.ex.inst    = raw;
        it.ex.op      = op;
        it.ex.alu_out = alu;
        it.ex.src2    = src2;
        it.wb.valid   = 1'b1;
        it.wb.pc      = next_pc;
        it.wb.inst    = raw;
        it.widx       = alu[8:3];
        it.is_store   = op inside {op_sb, op_sh, op_sw, op_sd};
        it.word       = '0;
        it.req.valid  = it.is_store || op inside {op_lb, op_lh, op_lw, op_ld,
                                                   op_lbu, op_lhu, op_lwu};
        it.req.we     = it.is_store;
        it.req.addr   = alu;
        it.req.wdata  = '0;
        it.req.strb   = '0;
        value         = '0;
        if (it.is_store) begin
            // previous writer of rs2 wins, never for x0
            data = (prev_writer && prev_rd == rs2 && rs2 != 0) ? prev_val : src2;
            shadow[it.widx] = store_word(shadow[it.widx], op, alu, data);
            it.word = shadow[it.widx];
            it.req.wdata = store_word('0, op, alu, data);
            it.req.strb  = store_strobe(op, alu);
        end else if (op == op_alu) begin
            value = alu;
        end else if (op == op_link) begin
            value = next_pc + 4;
        end else if (op == op_csr) begin
            value = src2;
        end else begin
            value = load_value(shadow[it.widx], op, alu);
        end
        it.rf.wen   = !it.is_store;
        it.rf.rd    = rd;
        it.rf.value = value;
        prev_writer = op inside {op_alu, op_csr, op_lb, op_lh, op_lw, op_ld,
                                 op_lbu, op_lhu, op_lwu};
        prev_rd     = rd;
        prev_val    = value;
        prog.push_back(it);
        next_pc += 4;
    endtask

    task automatic build_program();
        int unsigned b;
        int unsigned off;
        mem_op_t     op;
        // alu, link and csr
        for (int i = 0; i < 4; i++) begin
            add_inst(op_alu, reg_idx_t'(i + 1), 5'd0, {$urandom, $urandom}, '0);
            add_inst(op_link, reg_idx_t'(i + 8), 5'd0, '0, '0);
            add_inst(op_csr, reg_idx_t'(i + 12), 5'd0, '0, {$urandom, $urandom});
        end
        // every store size at every aligned offset
        for (int s = 0; s < 4; s++) begin
            b = access_bytes(st_ops[s]);
            for (off = 0; off < 8; off += b) begin
                add_inst(st_ops[s], reg_idx_t'($urandom), 5'd9, word_addr(4 + off, off),
                         {$urandom, $urandom});
            end
        end
        // every load size and offset, signed and unsigned
        for (int l = 0; l < 7; l++) begin
            b = access_bytes(ld_ops[l]);
            for (off = 0; off < 8; off += b) begin
                add_inst(ld_ops[l], 5'd10, 5'd0, word_addr($urandom % mem_words, off), '0);
            end
        end
        // forwarding into store data, and x0 which never forwards
        add_inst(op_alu, 5'd5, 5'd0, {$urandom, $urandom}, '0);
        add_inst(op_sd, 5'd0, 5'd5, word_addr(20, 0), 64'hdead_dead_dead_dead);
        add_inst(op_csr, 5'd7, 5'd0, '0, {$urandom, $urandom});
        add_inst(op_sw, 5'd1, 5'd7, word_addr(21, 4), 64'hbad0_bad0_bad0_bad0);
        add_inst(op_ld, 5'd11, 5'd0, word_addr(4, 0), '0);
        add_inst(op_sh, 5'd2, 5'd11, word_addr(22, 6), '0);
        add_inst(op_alu, 5'd0, 5'd0, {$urandom, $urandom}, '0);
        add_inst(op_sd, 5'd3, 5'd0, word_addr(23, 0), 64'h0123_4567_89ab_cdef);
        // random mix, small register range for frequent rs2 hits
        for (int i = 0; i < 60; i++) begin
            case ($urandom % 5)
                0:       add_inst(op_alu, reg_idx_t'($urandom % 8), 5'd0, {$urandom, $urandom}, '0);
                1:       add_inst(op_link, reg_idx_t'($urandom % 8), 5'd0, '0, '0);
                2:       add_inst(op_csr, reg_idx_t'($urandom % 8), 5'd0, '0, {$urandom, $urandom});
                3: begin
                    op  = ld_ops[$urandom % 7];
                    off = ($urandom % 8) & ~(access_bytes(op) - 1);
                    add_inst(op, reg_idx_t'($urandom % 8), 5'd0,
                             word_addr($urandom % mem_words, off), '0);
                end
                default: begin
                    op  = st_ops[$urandom % 4];
                    off = ($urandom % 8) & ~(access_bytes(op) - 1);
                    add_inst(op, reg_idx_t'($urandom), reg_idx_t'($urandom % 8),
                             word_addr($urandom % mem_words, off), {$urandom, $urandom});
                end
            endcase
        end
    endtask

    // ************************************************************
    // stimulus, execute side
    // ************************************************************
    initial begin
        int unsigned idx;
        void'($urandom(seed));
        rst            = 1'b1;
        ex             = '0;
        wb_ready       = 1'b0;
        fwd            = '0;
        dmem_ready     = 1'b0;
        cycles         = 0;
        retired        = 0;
        lat_cnt        = 0;
        word_check_due = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem_arr[i] = fill_word(word_addr(i, 0));
            shadow[i]  = mem_arr[i];
        end
        next_pc     = 64'h8000_0000;
        prev_writer = 1'b0;
        prev_rd     = '0;
        prev_val    = '0;
        build_program();
        limit = prog.size() * 12 + 100;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idx = 0;
        ex  <= prog[0].ex;
        while (idx < prog.size()) begin
            @(posedge clk);
            if (ex_ready) begin                    // captured at this edge
                idx++;
                if (idx < prog.size()) ex <= prog[idx].ex;
                else                   ex <= '0;
            end
        end
    end

    always @(posedge clk) begin
        wb_ready <= rst ? 1'b0 : ($urandom % 4 != 0);   // back-pressure 1 in 4
    end

    // write-back forwarding follows the last retirement
    always @(posedge clk) begin
        if (rst) begin
            fwd <= '0;
        end else if (wb.valid && wb_ready) begin
            fwd.valid <= 1'b1;
            fwd.inst  <= wb.inst;
            fwd.wdata <= rf_wr.value;
        end
    end

    // ************************************************************
    // data memory model, 0 to 3 wait cycles
    // ************************************************************
    task automatic pick_latency();
        int unsigned lat;
        lat = $urandom % 4;
        lat_cnt    <= lat;
        dmem_ready <= (lat == 0);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            dmem_ready <= 1'b0;
            lat_cnt    <= 0;
        end else if (dmem_req.valid && dmem_ready) begin
            if (dmem_req.we) begin
                for (int b = 0; b < 8; b++) begin
                    if (dmem_req.strb[b]) begin
                        mem_arr[dmem_req.addr[8:3]][b * 8 +: 8] <= dmem_req.wdata[b * 8 +: 8];
                    end
                end
            end
            if (wb_ready) pick_latency();          // stage moves on
        end else if (dmem_req.valid) begin
            lat_cnt    <= lat_cnt - 1;
            dmem_ready <= (lat_cnt <= 1);
        end else begin
            pick_latency();
        end
    end

    // ************************************************************
    // comparison and timeout
    // ************************************************************
    always @(posedge clk) begin
        inst_item_t exp;
        if (!rst) begin
            if (word_check_due) begin              // store landed last edge
                check_word("mem_arr word", mem_arr[check_widx], check_word_exp);
                word_check_due <= 1'b0;
            end
            if (wb.valid && wb_ready) begin
                if (retired >= prog.size()) begin
                    $display("an instruction retired after the whole program had retired");
                    stop_run();
                end
                exp = prog[retired];
                check_mem_wb(wb, exp.wb);
                check_rf_write(rf_wr, exp.rf);
                check_dmem_req(dmem_req, exp.req);
                if (exp.is_store) begin
                    word_check_due <= 1'b1;
                    check_widx     <= exp.widx;
                    check_word_exp <= exp.word;
                end
                retired <= retired + 1;
            end else if (retired == prog.size() && !word_check_due) begin
                $display("Simulation PASSED");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d instructions retired", cycles, retired);
            stop_run();
        end
    end

endmodule

// File: hdl/mem_stage.sv
// rv64 memory access stage
// stage register, store forwarding and alignment, load extraction
// and write-back selection around one data-memory port
module mem_stage import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // from execute
    input  ex_mem_t   ex,
    output logic      ex_ready,
    // to write-back
    output mem_wb_t   wb,
    input  logic      wb_ready,
    output rf_write_t rf_wr,
    input  wb_fwd_t   fwd,
    // data memory
    output dmem_req_t dmem_req,
    input  logic      dmem_ready,
    input  xlen_t     dmem_rdata
);

    ex_mem_t stage;                                // registered entry
    logic    block;
    xlen_t   src2;                                 // after forwarding
    xlen_t   st_wdata;
    strb_t   st_strb;
    xlen_t   load_val;

    // ************************************************************
    // stage register and stall
    // ************************************************************
    mem_pipe_reg i_mem_pipe_reg (
        .clk        (clk),
        .rst        (rst),
        .ex         (ex),
        .wb_ready   (wb_ready),
        .dmem_ready (dmem_ready),
        .ex_ready   (ex_ready),
        .stage      (stage),
        .block      (block)
    );

    // ************************************************************
    // store path
    // ************************************************************
    store_forward i_store_forward (
        .stage (stage),
        .fwd   (fwd),
        .src2  (src2)
    );

    store_align i_store_align (
        .stage (stage),
        .src2  (src2),
        .wdata (st_wdata),
        .strb  (st_strb)
    );

    // data port request, held until dmem_ready
    assign dmem_req.valid = stage.valid && is_mem_op(stage.op);
    assign dmem_req.we    = stage.valid && is_store(stage.op);
    assign dmem_req.addr  = stage.alu_out;
    assign dmem_req.wdata = st_wdata;
    assign dmem_req.strb  = st_strb;

    // ************************************************************
    // load path and write-back
    // ************************************************************
    load_extract i_load_extract (
        .stage    (stage),
        .rdata    (dmem_rdata),          // same-cycle read data
        .load_val (load_val)
    );

    wb_select i_wb_select (
        .stage    (stage),
        .block    (block),
        .src2     (src2),
        .load_val (load_val),
        .wb       (wb),
        .rf_wr    (rf_wr)
    );

endmodule

// File: hdl/wb_select.sv
// write-back select
// chooses the register-file value per operation and drives the
// write-back bundle, both held off while the stage is blocked
module wb_select import mem_pkg::*; (
    input  ex_mem_t   stage,
    input  logic      block,
    input  xlen_t     src2,
    input  xlen_t     load_val,
    output mem_wb_t   wb,
    output rf_write_t rf_wr
);

    logic  live;                                   // entry leaves this cycle
    logic  wen;
    xlen_t value;

    assign live = stage.valid && !block;

    always_comb begin
        wen = stage.op != op_none && !is_store(stage.op);
        if (is_load(stage.op)) begin
            value = load_val;
        end else begin
            case (stage.op)
                op_alu:  value = stage.alu_out;
                op_link: value = stage.pc + xlen_t'(4);    // return address
                op_csr:  value = src2;                     // old csr value
                default: value = '0;
            endcase
        end
    end

    // ************************************************************
    // outputs
    // ************************************************************
    assign wb.valid    = live;
    assign wb.pc       = live ? stage.pc : '0;
    assign wb.inst     = live ? stage.inst : '0;

    assign rf_wr.wen   = live && wen;
    assign rf_wr.rd    = live ? stage.inst.rtype.rd : '0;
    assign rf_wr.value = live ? value : '0;

endmodule

// File: hdl/load_extract.sv
// load data extraction
// picks the addressed byte, half, word or double from the read word
// and sign or zero extends it to 64 bits
module load_extract import mem_pkg::*; (
    input  ex_mem_t stage,
    input  xlen_t   rdata,
    output xlen_t   load_val
);

    logic [2:0] off;
    xlen_t      shifted;                           // addressed data at bit 0
    logic       load_ok;

    assign off = stage.alu_out[2:0];

    // addressed byte down to lane 0
    assign shifted = rdata >> {off, 3'b000};

    // odd halfwords etc. return zero, as the store side drops them
    assign load_ok = is_load(stage.op) && is_aligned(stage.op, off);

    // ************************************************************
    // extension
    // ************************************************************
    always_comb begin
        if (!load_ok) begin
            load_val = '0;
        end else begin
            case (stage.op)
                op_lb:   load_val = {{(xlen-8){shifted[7]}}, shifted[7:0]};
                op_lh:   load_val = {{(xlen-16){shifted[15]}}, shifted[15:0]};
                op_lw:   load_val = {{(xlen-32){shifted[31]}}, shifted[31:0]};
                op_lbu:  load_val = {{(xlen-8){1'b0}}, shifted[7:0]};
                op_lhu:  load_val = {{(xlen-16){1'b0}}, shifted[15:0]};
                op_lwu:  load_val = {{(xlen-32){1'b0}}, shifted[31:0]};
                default: load_val = shifted;       // ld, offset is zero
            endcase
        end
    end

endmodule

// File: hdl/store_align.sv
// store lane alignment
// moves the low bytes of the store operand to their lanes in the
// 64-bit word and builds the byte strobe
module store_align import mem_pkg::*; (
    input  ex_mem_t stage,
    input  xlen_t   src2,
    output xlen_t   wdata,
    output strb_t   strb
);

    logic [2:0] off;                               // byte offset in word
    strb_t      lanes;                             // size mask at lane 0
    xlen_t      data_mask;
    logic       store_ok;

    assign off = stage.alu_out[2:0];

    // ************************************************************
    // size masks
    // ************************************************************
    always_comb begin
        case (op_size(stage.op))
            2'd0:    lanes = 8'h01;
            2'd1:    lanes = 8'h03;
            2'd2:    lanes = 8'h0f;
            default: lanes = 8'hff;
        endcase
    end

    // byte mask to bit mask
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            data_mask[i*8 +: 8] = {8{lanes[i]}};
        end
    end

    // misaligned half/word/double get nothing
    assign store_ok = is_store(stage.op) && is_aligned(stage.op, off);

    // ************************************************************
    // shift into place
    // ************************************************************
    always_comb begin
        if (store_ok) begin
            wdata = (src2 & data_mask) << {off, 3'b000};
            strb  = lanes << off;
        end else begin
            wdata = '0;
            strb  = '0;
        end
    end

    // flags misaligned stores coming from execute
    always_comb begin
        if (stage.valid && is_store(stage.op)) begin
            store_strb_nonzero: assert final (strb != '0)
                else $error("store at %h has an empty byte strobe", stage.alu_out);
        end
    end

endmodule

// File: hdl/store_forward.sv
// store data forwarding
// a store whose rs2 is being written by the instruction in write-back
// takes that value instead of the stale operand from execute
module store_forward import mem_pkg::*; (
    input  ex_mem_t stage,
    input  wb_fwd_t fwd,
    output xlen_t   src2
);

    inst_r_t wb_r;                                 // wb inst, register view
    logic    wb_writer;                            // wb inst writes rd
    logic    rs2_match;

    assign wb_r = fwd.inst.rtype;

    // ************************************************************
    // write-back instruction class
    // ************************************************************
    always_comb begin
        case (wb_r.opcode)
            opc_load:      wb_writer = wb_r.funct3 != 3'b111;
            opc_op_imm: begin
                case (wb_r.funct3)
                    3'b001:  wb_writer = wb_r.funct7[6:1] == 6'b000000;   // slli
                    3'b101:  wb_writer = wb_r.funct7[6:1] inside {6'b000000, 6'b010000};
                    default: wb_writer = 1'b1;
                endcase
            end
            opc_op_imm_32: begin
                case (wb_r.funct3)
                    3'b000:  wb_writer = 1'b1;                            // addiw
                    3'b001:  wb_writer = wb_r.funct7 == 7'b0000000;
                    3'b101:  wb_writer = wb_r.funct7 inside {7'b0000000, 7'b0100000};
                    default: wb_writer = 1'b0;
                endcase
            end
            opc_op:        wb_writer = (wb_r.funct7 inside {7'b0000000, 7'b0000001})
                                    || (wb_r.funct7 == 7'b0100000
                                        && wb_r.funct3 inside {3'b000, 3'b101});
            opc_op_32:     wb_writer = (wb_r.funct7 == 7'b0000000
                                        && wb_r.funct3 inside {3'b000, 3'b001, 3'b101})
                                    || (wb_r.funct7 == 7'b0100000
                                        && wb_r.funct3 inside {3'b000, 3'b101})
                                    || (wb_r.funct7 == 7'b0000001
                                        && wb_r.funct3 != 3'b001
                                        && wb_r.funct3 != 3'b010
                                        && wb_r.funct3 != 3'b011);    // mulw/div*/rem*
            opc_lui,
            opc_auipc:     wb_writer = 1'b1;
            opc_system:    wb_writer = wb_r.funct3 inside {3'b001, 3'b010};   // csrrw/csrrs
            default:       wb_writer = 1'b0;
        endcase
    end

    // x0 never forwards
    assign rs2_match = (wb_r.rd == stage.inst.stype.rs2) && (stage.inst.stype.rs2 != '0);

    assign src2 = (stage.valid && is_store(stage.op) && fwd.valid && wb_writer && rs2_match)
                ? fwd.wdata
                : stage.src2;

endmodule

// File: hdl/mem_pipe_reg.sv
// execute to memory stage register
// holds its entry while a load/store waits on the data port or
// while write-back is not ready, and derives the stall signals
module mem_pipe_reg import mem_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex,
    input  logic    wb_ready,
    input  logic    dmem_ready,
    output logic    ex_ready,
    output ex_mem_t stage,
    output logic    block
);

    logic mem_busy;                                // entry is a ld/st

    // ************************************************************
    // stall logic
    // ************************************************************
    assign mem_busy = stage.valid && is_mem_op(stage.op);

    // data port not done yet
    assign block = mem_busy && !dmem_ready;

    // stall wins over downstream ready
    assign ex_ready = block ? 1'b0 : wb_ready;

    // ************************************************************
    // stage register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (ex_ready) begin
            stage <= ex;                           // capture from execute
        end
        // only the valid bit is cleared, payload keeps whatever it had
        if (rst) begin
            stage.valid <= 1'b0;
        end
    end

    // a valid entry that could not advance must be unchanged next cycle
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (!ex_ready && stage.valid) |=> $stable(stage)
    ) else $error("mem stage entry changed while ex_ready low");

endmodule

// File: hdl/mem_pkg.sv
// memory stage package
// shared widths, operation codes, instruction views and port structs
package mem_pkg;

    localparam int xlen = 64;                     // rv64 data and address width

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [7:0]      strb_t;              // one bit per byte lane
    typedef logic [4:0]      reg_idx_t;

    // rv64 major opcodes
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_system    = 7'b1110011;

    typedef enum logic [3:0] {
        op_none, op_alu, op_link, op_csr,          // no mem access
        op_lb, op_lh, op_lw, op_ld,
        op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } mem_op_t;

    // ************************************************************
    // instruction word views
    // ************************************************************
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef union packed {
        inst_r_t rtype;                            // rd and class decode
        inst_s_t stype;                            // store source reg
    } inst_t;

    // ************************************************************
    // port bundles
    // ************************************************************
    typedef struct packed {
        logic    valid;
        xlen_t   pc;
        inst_t   inst;
        mem_op_t op;
        xlen_t   alu_out;                          // address for ld/st
        xlen_t   src2;
    } ex_mem_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } mem_wb_t;

    typedef struct packed {
        logic     wen;
        reg_idx_t rd;
        xlen_t    value;
    } rf_write_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
        xlen_t wdata;
    } wb_fwd_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        xlen_t addr;
        xlen_t wdata;
        strb_t strb;
    } dmem_req_t;

    // op classes
    function automatic logic is_load(mem_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    function automatic logic is_mem_op(mem_op_t op);
        return is_load(op) || is_store(op);
    endfunction

    // log2 of access size in bytes
    function automatic logic [1:0] op_size(mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 2'd0;
            op_lh, op_lhu, op_sh: return 2'd1;
            op_lw, op_lwu, op_sw: return 2'd2;
            default:              return 2'd3;
        endcase
    endfunction

    // natural alignment of the low address bits
    function automatic logic is_aligned(mem_op_t op, logic [2:0] off);
        logic [2:0] low_mask;
        case (op_size(op))
            2'd0:    low_mask = 3'b000;
            2'd1:    low_mask = 3'b001;
            2'd2:    low_mask = 3'b011;
            default: low_mask = 3'b111;
        endcase
        return (off & low_mask) == 3'b000;
    endfunction

endpackage
